//--- include/lsq_settings.svh
`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// Queue geometry
`define LSQ_DEPTH 8
`define LSQ_PTR_W 3

// Datapath widths
`define LSQ_DATA_W 32
`define LSQ_TAG_W 3
`define LSQ_PREG_W 6

// Tag value for an operand that is already present
`define LSQ_TAG_READY 0

`endif

//--- source/lsq_pkg.sv
`default_nettype none

`include "lsq_settings.svh"

package lsq_pkg;

   // Address or data word
   typedef logic [`LSQ_DATA_W-1:0] data_t;

   // Producer tag on the result bus
   typedef logic [`LSQ_TAG_W-1:0] tag_t;

   // Physical destination register of a load
   typedef logic [`LSQ_PREG_W-1:0] preg_t;

   // Wrap pointer, top bit marks the lap
   typedef logic [`LSQ_PTR_W:0] lsq_ptr_t;

   // Occupancy, 0 up to LSQ_DEPTH
   typedef logic [`LSQ_PTR_W:0] lsq_count_t;

   // 0 byte, 1 halfword, 2 word
   typedef logic [1:0] mem_size_t;

   // One bit per byte lane
   typedef logic [3:0] byte_en_t;

   typedef enum logic [1:0] {
      ISSUE_IDLE,
      ISSUE_WAIT_RESP,
      ISSUE_DONE
   } issue_state_e;

endpackage

`default_nettype wire

//--- source/lsq_alloc_if.sv
`timescale 1ns/100ps
`default_nettype none

interface lsq_alloc_if;
   import lsq_pkg::*;

   logic      alloc_valid;
   logic      is_store;
   preg_t     phys_reg;
   mem_size_t size;

   // Operands, resolved at allocation or left for the snoop
   logic      addr_valid;
   data_t     address;
   logic      data_valid;
   data_t     data;
   tag_t      addr_tag;
   tag_t      data_tag;

   logic      full;

   modport dispatch (
      output alloc_valid, is_store, phys_reg, size,
      output addr_valid, address, data_valid, data, addr_tag, data_tag,
      input  full
   );

   modport buffer (
      input  alloc_valid, is_store, phys_reg, size,
      input  addr_valid, address, data_valid, data, addr_tag, data_tag,
      output full
   );

endinterface

`default_nettype wire

//--- source/lsq_head_if.sv
`timescale 1ns/100ps
`default_nettype none

interface lsq_head_if;
   import lsq_pkg::*;

   // Head exists and all of its operands are present
   logic      head_ready;

   // Head entry contents
   logic      is_store;
   data_t     address;
   data_t     data;
   mem_size_t size;
   preg_t     phys_reg;

   // Pulse that frees the head entry
   logic      retire;

   modport buffer (
      output head_ready,
      output is_store, address, data, size, phys_reg,
      input  retire
   );

   modport issue (
      input  head_ready,
      input  is_store, address, data, size, phys_reg,
      output retire
   );

endinterface

`default_nettype wire

//--- source/lsq_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_dispatch (
   // Allocation request from issue
   input  wire logic              alloc_valid_i,
   input  wire logic              alloc_is_store_i,
   input  wire lsq_pkg::preg_t    alloc_phys_reg_i,
   input  wire lsq_pkg::tag_t     alloc_addr_tag_i,
   input  wire lsq_pkg::data_t    alloc_data_i,
   input  wire lsq_pkg::tag_t     alloc_data_tag_i,
   input  wire lsq_pkg::mem_size_t alloc_size_i,

   // Result bus
   input  wire logic              cdb_valid_i,
   input  wire lsq_pkg::tag_t     cdb_tag_i,
   input  wire lsq_pkg::data_t    cdb_data_i,

   lsq_alloc_if.dispatch          alloc
);
   import lsq_pkg::*;

   logic addr_hit;
   logic data_hit;
   logic data_ready;

   // Same-cycle bus hits, so a result sent during allocation is kept
   assign addr_hit   = cdb_valid_i && (alloc_addr_tag_i == cdb_tag_i);
   assign data_hit   = cdb_valid_i && (alloc_data_tag_i == cdb_tag_i);
   assign data_ready = (alloc_data_tag_i == tag_t'(`LSQ_TAG_READY));

   assign alloc.alloc_valid = alloc_valid_i && !alloc.full;
   assign alloc.is_store    = alloc_is_store_i;
   assign alloc.phys_reg    = alloc_phys_reg_i;
   assign alloc.size        = alloc_size_i;
   assign alloc.addr_tag    = alloc_addr_tag_i;
   assign alloc.data_tag    = alloc_data_tag_i;

   // Addresses always come from a producer
   assign alloc.addr_valid  = addr_hit;
   assign alloc.address     = cdb_data_i;

   always_comb begin
      alloc.data_valid = 1'b0;
      alloc.data       = cdb_data_i;
      if (!alloc_is_store_i) begin
         // Loads carry no store datum
         alloc.data_valid = 1'b1;
      end else if (data_ready) begin
         alloc.data_valid = 1'b1;
         alloc.data       = alloc_data_i;
      end else if (data_hit) begin
         alloc.data_valid = 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- source/lsq_entry_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_entry_buffer (
   input  wire logic              clk,
   input  wire logic              rst_n,

   lsq_alloc_if.buffer            alloc,

   // Result bus
   input  wire logic              cdb_valid_i,
   input  wire lsq_pkg::tag_t     cdb_tag_i,
   input  wire lsq_pkg::data_t    cdb_data_i,

   lsq_head_if.buffer             head,

   output lsq_pkg::lsq_count_t    count_o,
   output logic                   full_o,
   output logic                   empty_o
);
   import lsq_pkg::*;

   // ============================================================
   // Entry storage
   // ============================================================

   logic      valid_q      [`LSQ_DEPTH];
   logic      addr_valid_q [`LSQ_DEPTH];
   logic      data_valid_q [`LSQ_DEPTH];

   logic      is_store_q   [`LSQ_DEPTH];
   preg_t     phys_reg_q   [`LSQ_DEPTH];
   mem_size_t size_q       [`LSQ_DEPTH];
   data_t     address_q    [`LSQ_DEPTH];
   data_t     data_q       [`LSQ_DEPTH];
   tag_t      addr_tag_q   [`LSQ_DEPTH];
   tag_t      data_tag_q   [`LSQ_DEPTH];

   lsq_ptr_t  head_ptr;
   lsq_ptr_t  tail_ptr;

   logic [`LSQ_PTR_W-1:0] head_idx;
   logic [`LSQ_PTR_W-1:0] tail_idx;

   logic addr_hit [`LSQ_DEPTH];
   logic data_hit [`LSQ_DEPTH];

   assign head_idx = head_ptr[`LSQ_PTR_W-1:0];
   assign tail_idx = tail_ptr[`LSQ_PTR_W-1:0];

   assign count_o    = lsq_count_t'(tail_ptr - head_ptr);
   assign full_o     = (count_o == lsq_count_t'(`LSQ_DEPTH));
   assign empty_o    = (count_o == '0);
   assign alloc.full = full_o;

   // Snoop matches for stored entries still waiting on an operand
   always_comb begin
      for (int i = 0; i < `LSQ_DEPTH; i++) begin
         addr_hit[i] = valid_q[i] && !addr_valid_q[i] && cdb_valid_i &&
                       (addr_tag_q[i] == cdb_tag_i);
         data_hit[i] = valid_q[i] && !data_valid_q[i] && cdb_valid_i &&
                       (data_tag_q[i] == cdb_tag_i);
      end
   end

   // Pointers and status bits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         head_ptr <= '0;
         tail_ptr <= '0;
         for (int i = 0; i < `LSQ_DEPTH; i++) begin
            valid_q[i]      <= 1'b0;
            addr_valid_q[i] <= 1'b0;
            data_valid_q[i] <= 1'b0;
         end
      end else begin
         for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (addr_hit[i]) begin
               addr_valid_q[i] <= 1'b1;
            end
            if (data_hit[i]) begin
               data_valid_q[i] <= 1'b1;
            end
         end
         // Tail slot is never valid, so no clash with the snoop
         if (alloc.alloc_valid) begin
            valid_q[tail_idx]      <= 1'b1;
            addr_valid_q[tail_idx] <= alloc.addr_valid;
            data_valid_q[tail_idx] <= alloc.data_valid;
            tail_ptr               <= tail_ptr + 1'b1;
         end
         if (head.retire) begin
            valid_q[head_idx] <= 1'b0;
            head_ptr          <= head_ptr + 1'b1;
         end
      end
   end

   // Entry payload
   always_ff @(posedge clk) begin
      for (int i = 0; i < `LSQ_DEPTH; i++) begin
         if (addr_hit[i]) begin
            address_q[i] <= cdb_data_i;
         end
         if (data_hit[i]) begin
            data_q[i] <= cdb_data_i;
         end
      end
      if (alloc.alloc_valid) begin
         is_store_q[tail_idx] <= alloc.is_store;
         phys_reg_q[tail_idx] <= alloc.phys_reg;
         size_q[tail_idx]     <= alloc.size;
         address_q[tail_idx]  <= alloc.address;
         data_q[tail_idx]     <= alloc.data;
         addr_tag_q[tail_idx] <= alloc.addr_tag;
         data_tag_q[tail_idx] <= alloc.data_tag;
      end
   end

   // ============================================================
   // Head entry
   // ============================================================

   assign head.head_ready = !empty_o && valid_q[head_idx] &&
                            addr_valid_q[head_idx] && data_valid_q[head_idx];
   assign head.is_store   = is_store_q[head_idx];
   assign head.address    = address_q[head_idx];
   assign head.data       = data_q[head_idx];
   assign head.size       = size_q[head_idx];
   assign head.phys_reg   = phys_reg_q[head_idx];

   // Dispatch must hold back when the queue is full
   a_no_alloc_when_full: assert property (
      @(posedge clk) disable iff (!rst_n) alloc.alloc_valid |-> !full_o
   );

   // The issue machine only retires an existing head
   a_no_retire_when_empty: assert property (
      @(posedge clk) disable iff (!rst_n) head.retire |-> !empty_o
   );

endmodule

`default_nettype wire

//--- source/lsq_mem_issue.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_mem_issue (
   input  wire logic              clk,
   input  wire logic              rst_n,

   lsq_head_if.issue              head,

   // Memory request
   output logic                   mem_req_valid_o,
   output logic                   mem_req_is_store_o,
   output lsq_pkg::data_t         mem_req_addr_o,
   output lsq_pkg::data_t         mem_req_data_o,
   output lsq_pkg::byte_en_t      mem_req_be_o,
   output lsq_pkg::mem_size_t     mem_req_size_o,
   input  wire logic              mem_req_ready_i,

   // Memory response
   input  wire logic              mem_resp_valid_i,
   input  wire lsq_pkg::data_t    mem_resp_data_i,

   // Load result
   output logic                   result_valid_o,
   output lsq_pkg::preg_t         result_preg_o,
   output lsq_pkg::data_t         result_data_o
);
   import lsq_pkg::*;

   issue_state_e state;
   logic         req_valid_q;
   data_t        resp_data_q;

   function automatic byte_en_t byte_enable(input logic [1:0] offset, input mem_size_t size);
      byte_en_t be;
      case (size)
         2'd0:    be = byte_en_t'(4'b0001 << offset);
         2'd1:    be = offset[1] ? 4'b1100 : 4'b0011;
         default: be = 4'b1111;
      endcase
      return be;
   endfunction

   // ============================================================
   // Issue FSM
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= ISSUE_IDLE;
         req_valid_q <= 1'b0;
      end else begin
         case (state)
            ISSUE_IDLE: begin
               if (req_valid_q) begin
                  if (mem_req_ready_i) begin
                     req_valid_q <= 1'b0;
                     state       <= ISSUE_WAIT_RESP;
                  end
               end else if (head.head_ready) begin
                  req_valid_q <= 1'b1;
               end
            end
            ISSUE_WAIT_RESP: begin
               if (mem_resp_valid_i) begin
                  state <= ISSUE_DONE;
               end
            end
            // One cycle only, the head retires here
            ISSUE_DONE: state <= ISSUE_IDLE;
            default:    state <= ISSUE_IDLE;
         endcase
      end
   end

   // Load data from memory
   always_ff @(posedge clk) begin
      if (state == ISSUE_WAIT_RESP && mem_resp_valid_i) begin
         resp_data_q <= mem_resp_data_i;
      end
   end

   // Head fields hold still until retire, so the request is stable
   assign mem_req_valid_o    = req_valid_q;
   assign mem_req_is_store_o = head.is_store;
   assign mem_req_addr_o     = head.address;
   assign mem_req_data_o     = head.data;
   assign mem_req_size_o     = head.size;
   assign mem_req_be_o       = byte_enable(head.address[1:0], head.size);

   assign head.retire    = (state == ISSUE_DONE);
   assign result_valid_o = (state == ISSUE_DONE) && !head.is_store;
   assign result_preg_o  = head.phys_reg;
   assign result_data_o  = resp_data_q;

   a_req_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      mem_req_valid_o && !mem_req_ready_i |=>
         mem_req_valid_o && $stable(mem_req_is_store_o) && $stable(mem_req_addr_o) &&
         $stable(mem_req_data_o) && $stable(mem_req_be_o) && $stable(mem_req_size_o)
   );

endmodule

`default_nettype wire

//--- source/lsq_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_top (
   input  wire logic              clk,
   input  wire logic              rst_n,

   // Allocation from issue
   input  wire logic              alloc_valid_i,
   input  wire logic              alloc_is_store_i,
   input  wire lsq_pkg::preg_t    alloc_phys_reg_i,
   input  wire lsq_pkg::tag_t     alloc_addr_tag_i,
   input  wire lsq_pkg::data_t    alloc_data_i,
   input  wire lsq_pkg::tag_t     alloc_data_tag_i,
   input  wire lsq_pkg::mem_size_t alloc_size_i,
   output logic                   alloc_ready_o,

   // Result bus
   input  wire logic              cdb_valid_i,
   input  wire lsq_pkg::tag_t     cdb_tag_i,
   input  wire lsq_pkg::data_t    cdb_data_i,

   // Memory request
   output logic                   mem_req_valid_o,
   output logic                   mem_req_is_store_o,
   output lsq_pkg::data_t         mem_req_addr_o,
   output lsq_pkg::data_t         mem_req_data_o,
   output lsq_pkg::byte_en_t      mem_req_be_o,
   output lsq_pkg::mem_size_t     mem_req_size_o,
   input  wire logic              mem_req_ready_i,

   // Memory response
   input  wire logic              mem_resp_valid_i,
   input  wire lsq_pkg::data_t    mem_resp_data_i,

   // Load result
   output logic                   result_valid_o,
   output lsq_pkg::preg_t         result_preg_o,
   output lsq_pkg::data_t         result_data_o,

   // Status
   output lsq_pkg::lsq_count_t    lsq_count_o,
   output logic                   lsq_full_o,
   output logic                   lsq_empty_o
);

   lsq_alloc_if alloc_bus ();
   lsq_head_if  head_bus ();

   assign alloc_ready_o = !lsq_full_o;

   lsq_dispatch lsq_dispatch_inst (
      .alloc_valid_i    (alloc_valid_i),
      .alloc_is_store_i (alloc_is_store_i),
      .alloc_phys_reg_i (alloc_phys_reg_i),
      .alloc_addr_tag_i (alloc_addr_tag_i),
      .alloc_data_i     (alloc_data_i),
      .alloc_data_tag_i (alloc_data_tag_i),
      .alloc_size_i     (alloc_size_i),
      .cdb_valid_i      (cdb_valid_i),
      .cdb_tag_i        (cdb_tag_i),
      .cdb_data_i       (cdb_data_i),
      .alloc            (alloc_bus.dispatch)
   );

   lsq_entry_buffer lsq_entry_buffer_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .alloc       (alloc_bus.buffer),
      .cdb_valid_i (cdb_valid_i),
      .cdb_tag_i   (cdb_tag_i),
      .cdb_data_i  (cdb_data_i),
      .head        (head_bus.buffer),
      .count_o     (lsq_count_o),
      .full_o      (lsq_full_o),
      .empty_o     (lsq_empty_o)
   );

   lsq_mem_issue lsq_mem_issue_inst (
      .clk                (clk),
      .rst_n              (rst_n),
      .head               (head_bus.issue),
      .mem_req_valid_o    (mem_req_valid_o),
      .mem_req_is_store_o (mem_req_is_store_o),
      .mem_req_addr_o     (mem_req_addr_o),
      .mem_req_data_o     (mem_req_data_o),
      .mem_req_be_o       (mem_req_be_o),
      .mem_req_size_o     (mem_req_size_o),
      .mem_req_ready_i    (mem_req_ready_i),
      .mem_resp_valid_i   (mem_resp_valid_i),
      .mem_resp_data_i    (mem_resp_data_i),
      .result_valid_o     (result_valid_o),
      .result_preg_o      (result_preg_o),
      .result_data_o      (result_data_o)
   );

endmodule

`default_nettype wire

//--- test/tb_lsq_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsq_settings.svh"

module tb_lsq_top;
   import lsq_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;

   typedef struct packed {
      logic      is_store;
      data_t     addr;
      data_t     data;
      byte_en_t  be;
      mem_size_t size;
   } mem_req_t;

   typedef struct packed {
      preg_t preg;
      data_t data;
   } load_result_t;

   // One allocated operation as the test expects to see it at memory
   typedef struct packed {
      logic      is_store;
      preg_t     preg;
      data_t     addr;
      data_t     data;
      mem_size_t size;
   } op_t;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       alloc_valid_i;
   logic       alloc_is_store_i;
   preg_t      alloc_phys_reg_i;
   tag_t       alloc_addr_tag_i;
   data_t      alloc_data_i;
   tag_t       alloc_data_tag_i;
   mem_size_t  alloc_size_i;
   logic       alloc_ready_o;
   logic       cdb_valid_i;
   tag_t       cdb_tag_i;
   data_t      cdb_data_i;
   logic       mem_req_valid_o;
   logic       mem_req_is_store_o;
   data_t      mem_req_addr_o;
   data_t      mem_req_data_o;
   byte_en_t   mem_req_be_o;
   mem_size_t  mem_req_size_o;
   logic       mem_req_ready_i = 1'b0;
   logic       mem_resp_valid_i = 1'b0;
   data_t      mem_resp_data_i = '0;
   logic       result_valid_o;
   preg_t      result_preg_o;
   data_t      result_data_o;
   lsq_count_t lsq_count_o;
   logic       lsq_full_o;
   logic       lsq_empty_o;

   // Memory model control and state
   logic       mem_hold = 1'b0;
   logic       rand_ready = 1'b0;
   logic       resp_wait = 1'b0;
   logic       req_pending = 1'b0;
   int         resp_delay = 0;
   mem_req_t   held_req;

   mem_req_t     req_log [$];
   load_result_t res_log [$];
   op_t          expected_ops [$];

   always #4 clk = ~clk;

   lsq_top lsq_top_inst (.*);

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("** Error at %0t: %s, got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
         $display("Errors found");
         $fatal(1);
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("Timeout after %0d cycles while waiting for %s", TIMEOUT_CYCLES, what);
      $display("Errors found");
      $fatal(1);
   endtask

   // Memory contents as a scramble of the whole address
   function automatic data_t mem_word(input data_t addr);
      return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
   endfunction

   function automatic byte_en_t expected_be(input data_t addr, input mem_size_t size);
      byte_en_t be;
      for (int lane = 0; lane < 4; lane++) begin
         if (size == 2'd2) begin
            be[lane] = 1'b1;
         end else if (size == 2'd1) begin
            be[lane] = (lane[1] == addr[1]);
         end else begin
            be[lane] = (lane[1:0] == addr[1:0]);
         end
      end
      return be;
   endfunction

   // ============================================================
   // Memory model and result monitor
   // ============================================================

   always @(negedge clk) begin
      mem_req_ready_i  = 1'b0;
      mem_resp_valid_i = 1'b0;
      if (rst_n && resp_wait) begin
         if (resp_delay == 0) begin
            mem_resp_valid_i = 1'b1;
            mem_resp_data_i  = mem_word(req_log[req_log.size() - 1].addr);
            resp_wait        = 1'b0;
         end else begin
            resp_delay--;
         end
      end else if (rst_n && mem_req_valid_o) begin
         // A waiting request must not change
         if (req_pending) begin
            check_equal(mem_req_addr_o, held_req.addr, "address held under back-pressure");
            check_equal(mem_req_data_o, held_req.data, "data held under back-pressure");
            check_equal(32'({mem_req_is_store_o, mem_req_be_o, mem_req_size_o}),
                        32'({held_req.is_store, held_req.be, held_req.size}),
                        "kind, byte enables and size held under back-pressure");
         end
         held_req = mem_req_t'{mem_req_is_store_o, mem_req_addr_o, mem_req_data_o,
                               mem_req_be_o, mem_req_size_o};
         req_pending = 1'b1;
         if (!mem_hold && (!rand_ready || $urandom_range(0, 1) == 1)) begin
            mem_req_ready_i = 1'b1;
            req_log.push_back(held_req);
            req_pending = 1'b0;
            resp_wait   = 1'b1;
            resp_delay  = $urandom_range(0, 4);
         end
      end
   end

   always @(negedge clk) begin
      if (rst_n && result_valid_o) begin
         res_log.push_back(load_result_t'{result_preg_o, result_data_o});
      end
   end

   // ============================================================
   // Stimulus helpers
   // ============================================================

   task automatic alloc_op(input logic is_store, input preg_t preg, input tag_t addr_tag,
                           input data_t data, input tag_t data_tag, input mem_size_t size);
      int cycles;
      cycles = 0;
      while (!alloc_ready_o) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            timeout_fail("allocation ready");
         end
      end
      alloc_valid_i    = 1'b1;
      alloc_is_store_i = is_store;
      alloc_phys_reg_i = preg;
      alloc_addr_tag_i = addr_tag;
      alloc_data_i     = data;
      alloc_data_tag_i = data_tag;
      alloc_size_i     = size;
      @(negedge clk);
      alloc_valid_i = 1'b0;
   endtask

   task automatic broadcast(input tag_t tag, input data_t value);
      cdb_valid_i = 1'b1;
      cdb_tag_i   = tag;
      cdb_data_i  = value;
      @(negedge clk);
      cdb_valid_i = 1'b0;
   endtask

   // Store data ready at allocation and the address from the bus one cycle later
   task automatic issue_op(input logic is_store, input preg_t preg, input tag_t tag,
                           input data_t addr, input data_t data, input mem_size_t size);
      alloc_op(is_store, preg, tag, data, tag_t'(`LSQ_TAG_READY), size);
      broadcast(tag, addr);
      expected_ops.push_back(op_t'{is_store, preg, addr, data, size});
   endtask

   // Waits for all expected requests and results and compares them in order
   task automatic drain_and_check();
      int expected_loads;
      int cycles;
      int res_idx;
      expected_loads = 0;
      foreach (expected_ops[i]) begin
         if (!expected_ops[i].is_store) begin
            expected_loads++;
         end
      end
      cycles = 0;
      while (req_log.size() < expected_ops.size() || res_log.size() < expected_loads ||
             !lsq_empty_o) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            timeout_fail("the queue to drain");
         end
      end
      check_equal(req_log.size(), expected_ops.size(), "number of memory requests");
      check_equal(res_log.size(), expected_loads, "number of load results");
      res_idx = 0;
      foreach (expected_ops[i]) begin
         check_equal(32'(req_log[i].is_store), 32'(expected_ops[i].is_store),
                     $sformatf("request %0d kind", i));
         check_equal(req_log[i].addr, expected_ops[i].addr, $sformatf("request %0d address", i));
         if (expected_ops[i].is_store) begin
            check_equal(req_log[i].data, expected_ops[i].data, $sformatf("request %0d data", i));
         end
         check_equal(32'(req_log[i].be),
                     32'(expected_be(expected_ops[i].addr, expected_ops[i].size)),
                     $sformatf("request %0d byte enables", i));
         check_equal(32'(req_log[i].size), 32'(expected_ops[i].size),
                     $sformatf("request %0d size", i));
         if (!expected_ops[i].is_store) begin
            check_equal(32'(res_log[res_idx].preg), 32'(expected_ops[i].preg),
                        $sformatf("result %0d register", res_idx));
            check_equal(res_log[res_idx].data, mem_word(expected_ops[i].addr),
                        $sformatf("result %0d data", res_idx));
            res_idx++;
         end
      end
      check_equal(32'(lsq_count_o), 32'd0, "count after drain");
      expected_ops.delete();
      req_log.delete();
      res_log.delete();
   endtask

   // ============================================================
   // Directed tests
   // ============================================================

   task automatic load_round_trip();
      issue_op(1'b0, 6'd5, 3'd3, 32'h0000_1008, 32'h0, 2'd2);
      issue_op(1'b0, 6'd9, 3'd4, 32'h0000_2003, 32'h0, 2'd0);
      drain_and_check();
   endtask

   // Every size at every aligned offset
   task automatic ready_data_stores();
      int n;
      n = 0;
      for (int size = 0; size < 3; size++) begin
         for (int offset = 0; offset < 4; offset += (1 << size)) begin
            issue_op(1'b1, preg_t'(n), tag_t'(n + 1), 32'h0000_3000 + 32'(16 * n + offset),
                     $urandom(), mem_size_t'(size));
            n++;
         end
      end
      drain_and_check();
   endtask

   task automatic bus_store_data();
      alloc_op(1'b1, 6'd0, 3'd1, 32'hdead_beef, 3'd2, 2'd2);
      broadcast(3'd1, 32'h0000_5000);
      broadcast(3'd2, 32'h1234_5678);
      expected_ops.push_back(op_t'{1'b1, 6'd0, 32'h0000_5000, 32'h1234_5678, 2'd2});
      // Data tag on the bus in the allocation cycle itself
      check_equal(32'(alloc_ready_o), 32'd1, "ready before same-cycle allocation");
      cdb_valid_i = 1'b1;
      cdb_tag_i   = 3'd4;
      cdb_data_i  = 32'h8765_4321;
      alloc_op(1'b1, 6'd0, 3'd3, 32'hdead_beef, 3'd4, 2'd1);
      cdb_valid_i = 1'b0;
      broadcast(3'd3, 32'h0000_5006);
      expected_ops.push_back(op_t'{1'b1, 6'd0, 32'h0000_5006, 32'h8765_4321, 2'd1});
      drain_and_check();
   endtask

   task automatic fill_and_drain();
      mem_hold = 1'b1;
      for (int i = 0; i < `LSQ_DEPTH; i++) begin
         issue_op(1'(i % 2), preg_t'(32 + i), tag_t'(i % 7 + 1),
                  32'h0000_6000 + 32'(8 * i + i % 4), $urandom(), mem_size_t'(i % 3));
      end
      check_equal(32'(lsq_full_o), 32'd1, "full flag");
      check_equal(32'(lsq_empty_o), 32'd0, "empty flag while full");
      check_equal(32'(alloc_ready_o), 32'd0, "allocation ready while full");
      check_equal(32'(lsq_count_o), `LSQ_DEPTH, "count when full");
      // Extra load offered while full
      alloc_valid_i    = 1'b1;
      alloc_is_store_i = 1'b0;
      alloc_phys_reg_i = 6'd63;
      alloc_addr_tag_i = 3'd7;
      alloc_data_tag_i = 3'd0;
      alloc_size_i     = 2'd2;
      repeat (3) @(negedge clk);
      alloc_valid_i = 1'b0;
      check_equal(32'(lsq_count_o), `LSQ_DEPTH, "count after refused allocation");
      mem_hold = 1'b0;
      drain_and_check();
   endtask

   task automatic random_back_pressure();
      rand_ready = 1'b1;
      for (int i = 0; i < 12; i++) begin
         issue_op(1'($urandom_range(0, 1)), preg_t'(40 + i), tag_t'(i % 7 + 1), $urandom(),
                  $urandom(), mem_size_t'($urandom_range(0, 2)));
      end
      drain_and_check();
      rand_ready = 1'b0;
   endtask

   initial begin
      void'($urandom(27813));
      rst_n            = 1'b0;
      alloc_valid_i    = 1'b0;
      alloc_is_store_i = 1'b0;
      alloc_phys_reg_i = '0;
      alloc_addr_tag_i = '0;
      alloc_data_i     = '0;
      alloc_data_tag_i = '0;
      alloc_size_i     = '0;
      cdb_valid_i      = 1'b0;
      cdb_tag_i        = '0;
      cdb_data_i       = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      check_equal(32'(alloc_ready_o), 32'd1, "allocation ready after reset");
      check_equal(32'(lsq_empty_o), 32'd1, "empty after reset");
      check_equal(32'(lsq_full_o), 32'd0, "full after reset");
      check_equal(32'(mem_req_valid_o), 32'd0, "request valid after reset");
      check_equal(32'(result_valid_o), 32'd0, "result valid after reset");

      load_round_trip();
      ready_data_stores();
      bus_store_data();
      fill_and_drain();
      random_back_pressure();

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
source/lsq_pkg.sv
source/lsq_alloc_if.sv
source/lsq_head_if.sv
source/lsq_dispatch.sv
source/lsq_entry_buffer.sv
source/lsq_mem_issue.sv
source/lsq_top.sv
test/tb_lsq_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the load-store queue testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f list.f --top-module tb_lsq_top -Mdir "$build_dir"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/Vtb_lsq_top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "Errors found" "$log_file"; then
   echo "Simulation failed"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi
echo "Simulation passed"
exit 0
